//--- hdl/farm_cfg_pkg.sv
/* Microgreen station monitor configuration
   Sample widths, channel numbers and per-channel comfort windows */

`default_nettype none

package farm_cfg_pkg;

    // ====================
    // Sample and channel sizing
    // ====================
    localparam int SAMPLE_W   = 8;    // Raw sensor sample
    localparam int NUM_CHAN   = 4;    // Soil, temp, humidity, light
    localparam int CHAN_W     = 2;    // Channel tag on each sample
    localparam int HIST_DEPTH = 4;    // Samples in running average
    localparam int SUM_W      = 10;   // Holds HIST_DEPTH * 255

    // Channel numbers as tagged on the sample input
    localparam logic [CHAN_W-1:0] CH_SOIL  = 2'd0;
    localparam logic [CHAN_W-1:0] CH_TEMP  = 2'd1;
    localparam logic [CHAN_W-1:0] CH_HUMID = 2'd2;
    localparam logic [CHAN_W-1:0] CH_LIGHT = 2'd3;

    // ====================
    // Comfort windows, pea microgreens
    // ====================
    localparam logic [SAMPLE_W-1:0] SOIL_MIN  = 8'd140;  // Too dry below
    localparam logic [SAMPLE_W-1:0] SOIL_MAX  = 8'd210;  // Waterlogged above
    localparam logic [SAMPLE_W-1:0] TEMP_MIN  = 8'd100;  // Too cold
    localparam logic [SAMPLE_W-1:0] TEMP_MAX  = 8'd160;  // Too hot
    localparam logic [SAMPLE_W-1:0] HUMID_MIN = 8'd120;
    localparam logic [SAMPLE_W-1:0] HUMID_MAX = 8'd190;
    localparam logic [SAMPLE_W-1:0] LIGHT_MIN = 8'd80;   // Too dark
    localparam logic [SAMPLE_W-1:0] LIGHT_MAX = 8'd220;  // Too bright

    // Window lookup tables, indexed by channel number
    localparam logic [SAMPLE_W-1:0] chan_min_t [NUM_CHAN] = '{
        CH_SOIL: SOIL_MIN, CH_TEMP: TEMP_MIN, CH_HUMID: HUMID_MIN, CH_LIGHT: LIGHT_MIN
    };
    localparam logic [SAMPLE_W-1:0] chan_max_t [NUM_CHAN] = '{
        CH_SOIL: SOIL_MAX, CH_TEMP: TEMP_MAX, CH_HUMID: HUMID_MAX, CH_LIGHT: LIGHT_MAX
    };

endpackage

`default_nettype wire

//--- hdl/farm_types_pkg.sv
/* Stage-to-stage payloads of the sensor monitor pipeline
   Averager result, checker result and the published status word */

`default_nettype none

package farm_types_pkg;

    import farm_cfg_pkg::*;

    // ====================
    // Stage 1 output
    // ====================
    typedef struct packed {
        logic                valid;  // Delayed sample strobe
        logic [CHAN_W-1:0]   chan;   // Channel of this sample
        logic [SAMPLE_W-1:0] raw;    // Sample as received
        logic [SAMPLE_W-1:0] avg;    // Four-sample mean incl. this one
    } avg_sample_t;

    // ====================
    // Stage 2 output
    // ====================
    typedef struct packed {
        logic                valid;
        logic [CHAN_W-1:0]   chan;
        logic [SAMPLE_W-1:0] avg;
        logic                alert;  // Average outside window
        logic                fault;  // Stuck or extreme reading
    } check_result_t;

    // ====================
    // Published status
    // ====================
    // Valid travels next to it as its own port
    typedef struct packed {
        logic [CHAN_W-1:0]   chan;        // Channel last updated
        logic [SAMPLE_W-1:0] avg;         // Its average
        logic [NUM_CHAN-1:0] alert_code;  // Bit per channel
        logic [NUM_CHAN-1:0] fault_code;  // Bit per channel
        logic                buzzer;      // Any alert or fault
    } monitor_status_t;

endpackage

`default_nettype wire

//--- hdl/sensor_averager.sv
/* Stage 1: four-sample history per channel and running mean
   Mean covers the sample just received */

`timescale 1ns/1ps
`default_nettype none

module sensor_averager
    import farm_cfg_pkg::*, farm_types_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                sample_valid,  // One sample per strobe
    input  wire logic [CHAN_W-1:0]   sample_chan,
    input  wire logic [SAMPLE_W-1:0] sample_data,
    output avg_sample_t              avg_out
);

    // ====================
    // Per-channel state
    // ====================
    logic [SAMPLE_W-1:0]           hist   [NUM_CHAN][HIST_DEPTH];  // Sample ring
    logic [$clog2(HIST_DEPTH)-1:0] wr_idx [NUM_CHAN];  // Oldest entry, own per channel
    logic [SUM_W-1:0]              sum    [NUM_CHAN];  // Sum of ring contents

    logic [SAMPLE_W-1:0] old_entry;  // Entry about to be replaced
    logic [SUM_W-1:0]    new_sum;    // Sum after replacement

    // Drop oldest, add newest
    // Cannot go negative, old entry is part of the sum
    assign old_entry = hist[sample_chan][wr_idx[sample_chan]];
    assign new_sum   = sum[sample_chan] - SUM_W'(old_entry) + SUM_W'(sample_data);

    // ====================
    // History update and output register
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avg_out.valid <= 1'b0;
            // Zero-filled ring, so first means ramp up
            for (int c = 0; c < NUM_CHAN; c++) begin
                for (int d = 0; d < HIST_DEPTH; d++) begin
                    hist[c][d] <= '0;
                end
                wr_idx[c] <= '0;
                sum[c]    <= '0;
            end
        end else begin
            avg_out.valid <= sample_valid;  // Fixed one-cycle latency
            if (sample_valid) begin
                hist[sample_chan][wr_idx[sample_chan]] <= sample_data;
                wr_idx[sample_chan] <= wr_idx[sample_chan] + 1'b1;  // Wraps at depth
                sum[sample_chan]    <= new_sum;

                avg_out.chan <= sample_chan;
                avg_out.raw  <= sample_data;
                avg_out.avg  <= new_sum[SUM_W-1 -: SAMPLE_W];  // Divide by four
            end
        end
    end

    // ====================
    // Checks
    // ====================
    // Sum must stay within a full ring of max samples
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_sum_chk
        a_sum_bound: assert property (
            @(posedge clk) disable iff (!rst_n)
            int'(sum[c]) <= HIST_DEPTH * ((1 << SAMPLE_W) - 1)
        ) else $error("averager: channel %0d sum out of range", c);
    end

endmodule

`default_nettype wire

//--- hdl/condition_checker.sv
/* Stage 2: window alert plus stuck and extreme fault per sample */

`timescale 1ns/1ps
`default_nettype none

module condition_checker
    import farm_cfg_pkg::*, farm_types_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  avg_sample_t  avg_in,
    output check_result_t check_out
);

    // ====================
    // Stuck detection state
    // ====================
    logic [SAMPLE_W-1:0] last_raw [NUM_CHAN];  // Previous raw reading
    logic [NUM_CHAN-1:0] seen;                 // Channel has a previous reading

    logic [SAMPLE_W-1:0] win_lo;
    logic [SAMPLE_W-1:0] win_hi;
    logic                out_of_win;
    logic                stuck;
    logic                extreme;

    // Window of the tagged channel
    assign win_lo = chan_min_t[avg_in.chan];
    assign win_hi = chan_max_t[avg_in.chan];

    assign out_of_win = (avg_in.avg < win_lo) || (avg_in.avg > win_hi);

    // Same raw value twice in a row on this channel
    assign stuck = seen[avg_in.chan] && (avg_in.raw == last_raw[avg_in.chan]);

    // Rail-to-rail mean, sensor open or shorted
    assign extreme = (avg_in.avg == '0) || (avg_in.avg == '1);

    // ====================
    // Result register
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            check_out.valid <= 1'b0;
            seen            <= '0;
            for (int c = 0; c < NUM_CHAN; c++) begin
                last_raw[c] <= '0;
            end
        end else begin
            check_out.valid <= avg_in.valid;
            if (avg_in.valid) begin
                last_raw[avg_in.chan] <= avg_in.raw;  // Compared against next time
                seen[avg_in.chan]     <= 1'b1;

                check_out.chan  <= avg_in.chan;
                check_out.avg   <= avg_in.avg;
                check_out.alert <= out_of_win;
                check_out.fault <= stuck || extreme;
            end
        end
    end

    // ====================
    // Checks
    // ====================
    // Result strobe is the input strobe one cycle late
    a_valid_lat: assert property (
        @(posedge clk) disable iff (!rst_n)
        check_out.valid == $past(avg_in.valid)
    ) else $error("checker: result valid lost step with input valid");

endmodule

`default_nettype wire

//--- hdl/alarm_reporter.sv
/* Stage 3: per-channel alert and fault codes, buzzer and status word */

`timescale 1ns/1ps
`default_nettype none

module alarm_reporter
    import farm_cfg_pkg::*, farm_types_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  check_result_t  check_in,
    output logic           status_valid,
    output monitor_status_t status        // Holds between results
);

    logic [NUM_CHAN-1:0] alert_next;  // Codes with this result merged in
    logic [NUM_CHAN-1:0] fault_next;
    logic                any_set;

    // ====================
    // Code merge
    // ====================
    // Codes live in the status register itself
    // Only the tagged channel's bit is overwritten
    always_comb begin
        alert_next = status.alert_code;
        fault_next = status.fault_code;
        alert_next[check_in.chan] = check_in.alert;
        fault_next[check_in.chan] = check_in.fault;
    end

    assign any_set = |{alert_next, fault_next};

    // ====================
    // Status register
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_valid <= 1'b0;
            status       <= '0;  // Codes and buzzer quiet
        end else begin
            status_valid <= check_in.valid;
            if (check_in.valid) begin
                status.chan       <= check_in.chan;
                status.avg        <= check_in.avg;
                status.alert_code <= alert_next;
                status.fault_code <= fault_next;
                status.buzzer     <= any_set;  // Sound on any channel problem
            end
        end
    end

    // ====================
    // Checks
    // ====================
    a_buzz_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        status.buzzer |-> (|{status.alert_code, status.fault_code})
    ) else $error("reporter: buzzer on with clean codes");

endmodule

`default_nettype wire

//--- hdl/farm_monitor_top.sv
/* Sensor monitor for the microgreen station
   Averager, condition checker and alarm reporter, three cycles end to end */

`timescale 1ns/1ps
`default_nettype none

module farm_monitor_top
    import farm_cfg_pkg::*, farm_types_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                sample_valid,  // No back-pressure
    input  wire logic [CHAN_W-1:0]   sample_chan,
    input  wire logic [SAMPLE_W-1:0] sample_data,
    output logic                     status_valid,  // Three cycles after sample
    output monitor_status_t          status
);

    avg_sample_t   avg_s;  // Stage 1 to 2
    check_result_t chk_s;  // Stage 2 to 3

    // ====================
    // Pipeline
    // ====================
    sensor_averager u_averager (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .avg_out      (avg_s)
    );

    condition_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .avg_in    (avg_s),
        .check_out (chk_s)
    );

    alarm_reporter u_reporter (
        .clk          (clk),
        .rst_n        (rst_n),
        .check_in     (chk_s),
        .status_valid (status_valid),
        .status       (status)
    );

endmodule

`default_nettype wire

//--- test/farm_model.svh
/* Reference model of the sensor monitor
   Mirrors histories, stuck tracking and codes to predict each status */

`ifndef FARM_MODEL_SVH
`define FARM_MODEL_SVH

// ====================
// Model state
// ====================
logic [SAMPLE_W-1:0] m_hist [NUM_CHAN][HIST_DEPTH];  // Last four samples
int                  m_next [NUM_CHAN];              // Slot for next sample
logic [SAMPLE_W-1:0] m_last [NUM_CHAN];              // Previous raw reading
bit                  m_seen [NUM_CHAN];
logic [NUM_CHAN-1:0] m_alert;                        // Alert bit per channel
logic [NUM_CHAN-1:0] m_fault;

// Same state the DUT holds after reset
function automatic void clear_model();
    for (int c = 0; c < NUM_CHAN; c++) begin
        for (int d = 0; d < HIST_DEPTH; d++) begin
            m_hist[c][d] = '0;
        end
        m_next[c] = 0;
        m_last[c] = '0;
        m_seen[c] = 1'b0;
    end
    m_alert = '0;
    m_fault = '0;
endfunction

// Takes one sample, returns the status it should produce
function automatic monitor_status_t predict_status(input logic [CHAN_W-1:0]   chan,
                                                   input logic [SAMPLE_W-1:0] data);
    monitor_status_t st;
    int              total;
    int              mean;
    bit              stuck;
    m_hist[chan][m_next[chan]] = data;               // Overwrite oldest
    m_next[chan] = (m_next[chan] + 1) % HIST_DEPTH;
    total = 0;
    for (int d = 0; d < HIST_DEPTH; d++) begin
        total += m_hist[chan][d];                    // Full re-sum every time
    end
    mean  = total / HIST_DEPTH;                      // Truncating
    stuck = m_seen[chan] && (data == m_last[chan]);
    m_alert[chan] = (mean < chan_min_t[chan]) || (mean > chan_max_t[chan]);
    m_fault[chan] = stuck || (mean == 0) || (mean == 255);
    m_last[chan]  = data;
    m_seen[chan]  = 1'b1;
    st.chan       = chan;
    st.avg        = SAMPLE_W'(mean);
    st.alert_code = m_alert;
    st.fault_code = m_fault;
    st.buzzer     = |{m_alert, m_fault};             // Any bit of either code
    return st;
endfunction

`endif

//--- test/tb_farm_monitor.sv
/* Testbench for the microgreen sensor monitor
   Directed and seeded random samples, checked against a reference model */

`timescale 1ns/1ps
`default_nettype none

module tb_farm_monitor
    import farm_cfg_pkg::*, farm_types_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                sample_valid;
    logic [CHAN_W-1:0]   sample_chan;
    logic [SAMPLE_W-1:0] sample_data;
    logic                status_valid;
    monitor_status_t     status;

    `include "farm_model.svh"

    // ====================
    // Scoreboard state
    // ====================
    monitor_status_t     exp_q [$];     // Predicted status per sample
    int                  due_q [$];     // Cycle each status is due
    monitor_status_t     got_q [$];     // Statuses seen in current test
    monitor_status_t     held_status;   // Last published status
    int                  cyc = 0;
    int                  err_count = 0;
    int                  check_count = 0;
    int                  sent_count = 0;
    int                  test_num = 0;
    int                  test_fail = 0;
    int                  test_err_base = 0;
    int                  seed;
    logic [31:0]         rnd;
    logic [NUM_CHAN-1:0] code_before;
    logic [CHAN_W-1:0]   b2b_chan [8];  // Order of back-to-back samples

    farm_monitor_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .status_valid (status_valid),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 125 MHz
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // Scoreboard, samples at falling edge
    // ====================
    always @(negedge clk) begin : scoreboard
        monitor_status_t exp_st;
        int              due;
        if (rst_n && status_valid) begin
            if (exp_q.size() == 0) begin
                $display("Status appeared on channel %0d with no sample outstanding",
                         status.chan);
                err_count++;
            end else begin
                exp_st = exp_q.pop_front();
                due    = due_q.pop_front();
                check_count++;
                if (status !== exp_st) begin
                    $display("[ERROR] %0t: got %0d %0d %b/%b/%b, expected %0d %0d %b/%b/%b",
                             $time, status.chan, status.avg, status.alert_code,
                             status.fault_code, status.buzzer, exp_st.chan, exp_st.avg,
                             exp_st.alert_code, exp_st.fault_code, exp_st.buzzer);
                    err_count++;
                end
                if (cyc != due) begin
                    $display("[ERROR] %0t: status at cycle %0d, expected cycle %0d",
                             $time, cyc, due);
                    err_count++;
                end
            end
            got_q.push_back(status);
            held_status = status;
        end else if (rst_n && (status !== held_status)) begin
            $display("[ERROR] %0t: status changed while status_valid low", $time);
            err_count++;
        end
    end

    // ====================
    // Driver tasks
    // ====================
    task automatic send_sample(input logic [CHAN_W-1:0] chan, input logic [SAMPLE_W-1:0] data);
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_chan  <= chan;
        sample_data  <= data;
        exp_q.push_back(predict_status(chan, data));
        due_q.push_back(cyc + 4);  // Out three edges after this one, cyc not yet bumped
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // Stop driving and wait for every predicted status
    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d statuses never arrived within %0d cycles",
                     exp_q.size(), limit);
            err_count++;
            exp_q.delete();
            due_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic start_test();
        test_num++;
        test_err_base = err_count;
        got_q.delete();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - test_err_base;
        if (errs == 0) begin
            $display("Test %0d (%s) passed", test_num, name);
        end else begin
            $display("Test %0d (%s) failed with %0d errors", test_num, name, errs);
            test_fail++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_chan  = '0;
        sample_data  = '0;
        held_status  = '0;
        seed         = 32'h7358_b3d8;
        clear_model();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet output with nothing sent
        start_test();
        repeat (10) begin
            @(negedge clk);
            if (status_valid || exp_q.size() != 0) begin
                $display("[ERROR] %0t: status_valid high with no sample sent", $time);
                err_count++;
            end
        end
        finish_test("idle after reset");

        // Zero-filled history ramps up in quarters
        start_test();
        repeat (4) send_sample(CH_TEMP, 8'd200);
        wait_drain(20);
        if (got_q.size() != 4) begin
            $display("[ERROR] %0t: %0d averages seen, expected 4", $time, got_q.size());
            err_count++;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (got_q[i].avg != SAMPLE_W'((200 * (i + 1)) / 4)) begin
                    $display("[ERROR] %0t: average %0d is %0d", $time, i, got_q[i].avg);
                    err_count++;
                end
            end
        end
        finish_test("averaging ramp");

        // In-window humidity, then pushed above its maximum
        start_test();
        repeat (4) send_sample(CH_HUMID, 8'd150);
        wait_drain(20);
        code_before = got_q[$].alert_code;
        if (code_before[CH_HUMID]) begin
            $display("[ERROR] %0t: humidity alert still set in window", $time);
            err_count++;
        end
        repeat (4) send_sample(CH_HUMID, 8'd250);
        wait_drain(20);
        if ((got_q[$].alert_code ^ code_before) != (4'b1 << CH_HUMID)) begin
            $display("[ERROR] %0t: alert code %b after %b, only humidity should change",
                     $time, got_q[$].alert_code, code_before);
            err_count++;
        end
        finish_test("window alerts");

        // Stuck light reading, then extreme soil average
        start_test();
        send_sample(CH_LIGHT, 8'd120);
        send_sample(CH_LIGHT, 8'd120);  // Repeat
        send_sample(CH_LIGHT, 8'd130);
        send_sample(CH_SOIL, 8'd2);     // Mean rounds to 0
        send_sample(CH_SOIL, 8'd100);
        wait_drain(20);
        if (got_q.size() != 5) begin
            $display("[ERROR] %0t: %0d statuses seen, expected 5", $time, got_q.size());
            err_count++;
        end else if (got_q[0].fault_code[CH_LIGHT] || !got_q[1].fault_code[CH_LIGHT] ||
                     got_q[2].fault_code[CH_LIGHT] || !got_q[3].fault_code[CH_SOIL] ||
                     got_q[4].fault_code[CH_SOIL]) begin
            $display("[ERROR] %0t: fault bits do not set and clear as expected", $time);
            err_count++;
        end
        finish_test("stuck and extreme faults");

        // Seeded random stream with gaps
        start_test();
        sent_count = 0;
        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                idle_cycle();  // Gap in the stream
            end
            rnd = $random(seed);
            send_sample(rnd[9:8], rnd[7:0]);
        end
        wait_drain(50);
        if (got_q.size() != sent_count) begin
            $display("[ERROR] %0t: %0d statuses for %0d samples", $time, got_q.size(),
                     sent_count);
            err_count++;
        end
        finish_test("random stream");

        // Valid held high, one status per sample in order
        start_test();
        for (int i = 0; i < 8; i++) begin
            b2b_chan[i] = CHAN_W'(i * 3);
            send_sample(b2b_chan[i], SAMPLE_W'(60 + i * 17));
        end
        wait_drain(20);
        if (got_q.size() != 8) begin
            $display("[ERROR] %0t: %0d statuses for 8 samples", $time, got_q.size());
            err_count++;
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (got_q[i].chan != b2b_chan[i]) begin
                    $display("[ERROR] %0t: status %0d on channel %0d, expected %0d",
                             $time, i, got_q[i].chan, b2b_chan[i]);
                    err_count++;
                end
            end
        end
        finish_test("back-to-back samples");

        $display("Tests %0d, failed %0d, statuses checked %0d, errors %0d",
                 test_num, test_fail, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
hdl/farm_cfg_pkg.sv
hdl/farm_types_pkg.sv
hdl/sensor_averager.sv
hdl/condition_checker.sv
hdl/alarm_reporter.sv
hdl/farm_monitor_top.sv
test/tb_farm_monitor.sv

//--- Makefile
# Verilator simulation of the microgreen sensor monitor

TOP := tb_farm_monitor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
